/* compile.f */
verilog/mod_pkg.sv
verilog/pipe_divider.sv
verilog/modulation_timer.sv
verilog/modulation_memory.sv
verilog/modulation_applier.sv
verilog/modulation_top.sv
verification/modulation_tb.sv

/* run.sh */
#!/bin/sh
# build and run the modulation testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
  --top-module modulation_tb -f compile.f -o sim_modulation
status=$?
if [ $status -ne 0 ]; then
  echo "build failed with status $status"
  exit 1
fi

./obj_dir/sim_modulation > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "TESTBENCH PASSED" sim.log; then
  echo "run passed"
  exit 0
else
  echo "run failed, see sim.log"
  exit 1
fi

/* verification/modulation_tb.sv */
module modulation_tb;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int drive_delay       = 10;
  localparam int steps_per_segment = 6;
  localparam int wrap_steps        = 5;
  localparam int fill_cycles       = mod_pkg::num_segment * mod_pkg::mem_depth;
  // test lengths in settle units with time steps counted double
  localparam int test_units = 1 + 3 + 4 * steps_per_segment + 1 + 3 + 2 * wrap_steps + 1;
  localparam int watchdog_cycles = fill_cycles + (test_units + 10) * mod_pkg::settle_cycles;

  logic                   CLK;
  logic                   rst_n;
  logic                   update_settings_in;
  logic [63:0]            sys_time;
  mod_pkg::mod_settings_t settings;
  logic                   segment;
  mod_pkg::mod_write_t    wr;
  logic [7:0]             intensity_in;
  logic                   intensity_valid;
  logic                   update_settings_out;
  logic [7:0]             intensity_out;
  logic                   intensity_out_valid;

  // reference model state
  logic [7:0]  mem_model [mod_pkg::num_segment][mod_pkg::mem_depth];
  logic [15:0] freq_model [mod_pkg::num_segment];
  logic [16:0] len_model [mod_pkg::num_segment];  // cycle+1
  int          load_left;
  logic        pulse_exp;
  logic [7:0]  sample_exp;
  logic [7:0]  exp_out;
  logic [7:0]  exp_d1;
  logic [7:0]  exp_d2;
  logic        valid_d1;
  logic        valid_d2;
  logic        check_en;
  logic        check_d1;
  logic        check_d2;

  logic [31:0] lcg_state = 32'hcf6a;
  int          err_cnt;
  int          pass_cnt;
  int          fail_cnt;

  modulation_top u_modulation_top (
    .CLK                 (CLK),
    .rst_n               (rst_n),
    .update_settings_in  (update_settings_in),
    .sys_time            (sys_time),
    .settings            (settings),
    .segment             (segment),
    .wr                  (wr),
    .intensity_in        (intensity_in),
    .intensity_valid     (intensity_valid),
    .update_settings_out (update_settings_out),
    .intensity_out       (intensity_out),
    .intensity_out_valid (intensity_out_valid)
  );

  initial begin
    CLK = 1'b0;
    forever #50 CLK = ~CLK;
  end

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic logic [63:0] random_time();
    logic [31:0] hi;
    logic [31:0] lo;
    hi = lcg_next();
    lo = lcg_next();
    return {hi, lo};
  endfunction

  function automatic logic [7:0] fill_value(input logic seg, input logic [14:0] addr);
    return addr[7:0] ^ {addr[14:8], seg};  // low byte folded with upper bits
  endfunction

  function automatic logic [14:0] expected_index(input logic [63:0] t, input logic [15:0] fdiv,
                                                 input logic [16:0] len);
    logic [47:0] count;
    logic [47:0] rem;
    count = t[mod_pkg::time_shift +: 48] / 48'(fdiv);
    rem   = count % 48'(len);
    return rem[14:0];
  endfunction

  ////////////////////
  // reference model
  ////////////////////

  always @(posedge CLK) begin
    if (!rst_n) begin
      load_left <= 0;
      pulse_exp <= 1'b0;
      for (int i = 0; i < mod_pkg::num_segment; i++) begin
        freq_model[i] <= 16'd1;
        len_model[i]  <= 17'd1;
      end
    end else begin
      pulse_exp <= (load_left == 1);
      if (load_left == 0 && update_settings_in) begin
        load_left <= mod_pkg::settle_cycles;
        for (int i = 0; i < mod_pkg::num_segment; i++) begin
          freq_model[i] <= settings.freq_div[i];
          len_model[i]  <= 17'(settings.cycle[i]) + 17'd1;
        end
      end else if (load_left != 0) begin
        load_left <= load_left - 1;
      end
    end
  end

  always @(posedge CLK) begin
    if (wr.en) mem_model[wr.segment][wr.addr] <= wr.data;
  end

  always_comb begin
    sample_exp = mem_model[segment][expected_index(sys_time, freq_model[segment],
                                                   len_model[segment])];
    exp_out    = 8'((int'(intensity_in) * (int'(sample_exp) + 1)) >> 8);
  end

  always @(posedge CLK) begin
    exp_d1   <= exp_out;  // two-cycle output latency
    exp_d2   <= exp_d1;
    valid_d1 <= intensity_valid;
    valid_d2 <= valid_d1;
    check_d1 <= check_en;
    check_d2 <= check_d1;
  end

  ////////////////////
  // checks
  ////////////////////

  pulse_check: assert property (@(posedge CLK) disable iff (!rst_n)
    update_settings_out == pulse_exp)
    else begin
      $display("Mismatch update_settings_out: got %h expected %h",
               $sampled(update_settings_out), $sampled(pulse_exp));
      err_cnt++;
    end

  valid_check: assert property (@(posedge CLK) disable iff (!rst_n)
    intensity_out_valid == valid_d2)
    else begin
      $display("Mismatch intensity_out_valid: got %h expected %h",
               $sampled(intensity_out_valid), $sampled(valid_d2));
      err_cnt++;
    end

  data_check: assert property (@(posedge CLK) disable iff (!rst_n)
    (check_d2 && valid_d2) |-> (intensity_out == exp_d2))
    else begin
      $display("Mismatch intensity_out: got %h expected %h",
               $sampled(intensity_out), $sampled(exp_d2));
      err_cnt++;
    end

  initial begin
    repeat (watchdog_cycles) @(posedge CLK);
    $display("timeout: the tests did not finish within %0d cycles", watchdog_cycles);
    $display("TESTBENCH FAILED");
    $finish;
  end

  ////////////////////
  // stimulus helpers
  ////////////////////

  task automatic step(input int n);
    repeat (n) @(posedge CLK);
    #drive_delay;
  endtask

  task automatic end_test(input string name, input int errs_before);
    if (err_cnt == errs_before) begin
      $display("%s: ok", name);
      pass_cnt++;
    end else begin
      $display("%s: %0d errors", name, err_cnt - errs_before);
      fail_cnt++;
    end
  endtask

  task automatic random_settings(output mod_pkg::mod_settings_t s);
    logic [31:0] r;
    for (int i = 0; i < mod_pkg::num_segment; i++) begin
      r             = lcg_next();
      s.cycle[i]    = r[14:0];
      s.freq_div[i] = r[31:16] | 16'd1;  // never zero
    end
  endtask

  task automatic request_settings(input mod_pkg::mod_settings_t s);
    settings           = s;
    update_settings_in = 1'b1;
    step(1);
    update_settings_in = 1'b0;
  endtask

  task automatic wait_settings_applied();
    int waited;
    waited = 0;
    while (!update_settings_out && waited < mod_pkg::settle_cycles + 8) begin
      step(1);
      waited++;
    end
    if (!update_settings_out) begin
      $display("settings-applied pulse did not arrive within %0d cycles", waited);
      err_cnt++;
    end
  endtask

  task automatic apply_time(input logic [63:0] t);
    check_en = 1'b0;
    sys_time = t;
    step(mod_pkg::settle_cycles);  // first check lands settle_cycles+3 after the change
    check_en = 1'b1;
    step(8);
  endtask

  ////////////////////
  // tests
  ////////////////////

  initial begin
    mod_pkg::mod_settings_t s_a;
    mod_pkg::mod_settings_t s_b;
    logic [31:0]            r;
    logic [14:0]            cur_idx;
    logic [7:0]             new_data;
    logic [47:0]            count;
    logic [15:0]            fdiv;
    logic [16:0]            len;
    int                     errs;

    rst_n              = 1'b0;
    update_settings_in = 1'b0;
    sys_time           = '0;
    settings           = '0;
    segment            = 1'b0;
    wr                 = '0;
    intensity_in       = '0;
    intensity_valid    = 1'b0;
    check_en           = 1'b0;
    err_cnt            = 0;
    pass_cnt           = 0;
    fail_cnt           = 0;
    step(10);
    rst_n = 1'b1;

    errs = err_cnt;
    step(20);  // strobes must stay low
    end_test("test 1 reset idle", errs);

    errs = err_cnt;
    random_settings(s_a);
    random_settings(s_b);
    request_settings(s_a);
    step(4);
    request_settings(s_b);  // lands in st_load and is ignored
    wait_settings_applied();
    step(mod_pkg::settle_cycles);
    end_test("test 2 settings pulse", errs);

    errs = err_cnt;
    for (int seg = 0; seg < mod_pkg::num_segment; seg++) begin
      for (int a = 0; a < mod_pkg::mem_depth; a++) begin
        wr = '{en: 1'b1, segment: 1'(seg), addr: 15'(a), data: fill_value(1'(seg), 15'(a))};
        step(1);
      end
    end
    wr              = '0;
    intensity_in    = 8'hff;
    intensity_valid = 1'b1;
    for (int seg = 0; seg < mod_pkg::num_segment; seg++) begin
      segment = 1'(seg);
      for (int n = 0; n < steps_per_segment; n++) begin
        apply_time(random_time());
      end
    end
    end_test("test 3 time stepping", errs);

    errs = err_cnt;
    for (int n = 0; n < 64; n++) begin
      r               = lcg_next();
      intensity_in    = r[7:0];
      intensity_valid = r[8] | r[9];  // mostly valid
      step(1);
    end
    intensity_in    = 8'hff;
    intensity_valid = 1'b1;
    step(3);
    end_test("test 4 intensity scaling", errs);

    errs     = err_cnt;
    check_en = 1'b0;
    for (int i = 0; i < mod_pkg::num_segment; i++) begin
      r              = lcg_next();
      s_a.cycle[i]    = 15'(2 + r[7:0] % 6);
      s_a.freq_div[i] = 16'(1 + r[15:8] % 4);
    end
    request_settings(s_a);
    wait_settings_applied();
    step(2);
    check_en = 1'b1;
    step(8);
    segment = 1'b1;
    fdiv    = s_a.freq_div[1];
    len     = 17'(s_a.cycle[1]) + 17'd1;
    r       = lcg_next();
    count   = 48'(len) * 48'(5 + r[6:0]) - 48'd2;  // crosses a wrap to 0
    for (int n = 0; n < wrap_steps; n++) begin
      r = lcg_next();
      apply_time({8'h00, (count + 48'(n)) * 48'(fdiv) + 48'(r[15:0] % fdiv), r[23:16]});
    end
    end_test("test 5 new settings and wrap", errs);

    errs     = err_cnt;
    cur_idx  = expected_index(sys_time, freq_model[1], len_model[1]);
    new_data = mem_model[1][cur_idx] ^ 8'ha5;
    wr       = '{en: 1'b1, segment: 1'b1, addr: cur_idx, data: new_data};
    step(1);
    wr.en = 1'b0;
    step(2);
    assert (intensity_out == new_data)
      else begin
        $display("Mismatch intensity_out after write: got %h expected %h",
                 intensity_out, new_data);
        err_cnt++;
      end
    wr = '{en: 1'b1, segment: 1'b0, addr: cur_idx, data: ~new_data};  // unselected segment
    step(1);
    wr.en = 1'b0;
    step(2);
    assert (intensity_out == new_data)
      else begin
        $display("Mismatch intensity_out after other-segment write: got %h expected %h",
                 intensity_out, new_data);
        err_cnt++;
      end
    step(4);
    end_test("test 6 host write", errs);

    $display("tests passed %0d, failed %0d", pass_cnt, fail_cnt);
    if (fail_cnt == 0 && err_cnt == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

/* verilog/modulation_top.sv */
module modulation_top (
  input  logic                             CLK,
  input  logic                             rst_n,
  input  logic                             update_settings_in,
  input  logic [63:0]                      sys_time,
  input  mod_pkg::mod_settings_t           settings,
  input  logic                             segment,
  input  mod_pkg::mod_write_t              wr,
  input  logic [mod_pkg::sample_width-1:0] intensity_in,
  input  logic                             intensity_valid,
  output logic                             update_settings_out,
  output logic [mod_pkg::sample_width-1:0] intensity_out,
  output logic                             intensity_out_valid
);

  mod_pkg::idx_array_t              idx;
  logic [mod_pkg::sample_width-1:0] mod_sample;

  modulation_timer u_timer (
    .CLK                 (CLK),
    .rst_n               (rst_n),
    .update_settings_in  (update_settings_in),
    .sys_time            (sys_time),
    .settings            (settings),
    .idx                 (idx),
    .update_settings_out (update_settings_out)
  );

  modulation_memory u_memory (
    .CLK        (CLK),
    .wr         (wr),
    .idx        (idx),
    .segment    (segment),
    .mod_sample (mod_sample)
  );

  // sample lags index by one cycle, applier covers it
  modulation_applier u_applier (
    .CLK                 (CLK),
    .rst_n               (rst_n),
    .intensity_in        (intensity_in),
    .intensity_valid     (intensity_valid),
    .mod_sample          (mod_sample),
    .intensity_out       (intensity_out),
    .intensity_out_valid (intensity_out_valid)
  );

endmodule

/* verilog/modulation_applier.sv */
module modulation_applier (
  input  logic                             CLK,
  input  logic                             rst_n,
  input  logic [mod_pkg::sample_width-1:0] intensity_in,
  input  logic                             intensity_valid,
  input  logic [mod_pkg::sample_width-1:0] mod_sample,
  output logic [mod_pkg::sample_width-1:0] intensity_out,
  output logic                             intensity_out_valid
);

  logic [mod_pkg::sample_width-1:0]   intensity_q;
  logic                               valid_q;
  logic [mod_pkg::sample_width:0]     scale;    // sample+1, up to 256
  logic [2*mod_pkg::sample_width-1:0] product;

  ////////////////////
  // align with memory read
  ////////////////////

  always_ff @(posedge CLK) begin
    intensity_q <= intensity_in;
  end

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      valid_q             <= 1'b0;
      intensity_out_valid <= 1'b0;
    end else begin
      valid_q             <= intensity_valid;
      intensity_out_valid <= valid_q;
    end
  end

  ////////////////////
  // scale
  ////////////////////

  assign scale   = {1'b0, mod_sample} + 1'b1;
  assign product = intensity_q * scale;  // max 255*256 fits 16 bits

  always_ff @(posedge CLK) begin
    intensity_out <= product[2*mod_pkg::sample_width-1:mod_pkg::sample_width];
  end

endmodule

/* verilog/modulation_memory.sv */
module modulation_memory (
  input  logic                             CLK,
  input  mod_pkg::mod_write_t              wr,
  input  mod_pkg::idx_array_t              idx,
  input  logic                             segment,
  output logic [mod_pkg::sample_width-1:0] mod_sample
);

  // one sample table per segment
  logic [mod_pkg::sample_width-1:0] mem [mod_pkg::num_segment][mod_pkg::mem_depth];

  logic [mod_pkg::idx_width-1:0] rd_addr;

  assign rd_addr = idx[segment];  // index of the selected segment

  ////////////////////
  // host write
  ////////////////////

  always_ff @(posedge CLK) begin
    if (wr.en) begin
      mem[wr.segment][wr.addr] <= wr.data;
    end
  end

  ////////////////////
  // sample read
  ////////////////////

  always_ff @(posedge CLK) begin
    mod_sample <= mem[segment][rd_addr];  // old data on same-cycle write
  end

endmodule

/* verilog/modulation_timer.sv */
module modulation_timer (
  input  logic                   CLK,
  input  logic                   rst_n,
  input  logic                   update_settings_in,
  input  logic [63:0]            sys_time,
  input  mod_pkg::mod_settings_t settings,
  output mod_pkg::idx_array_t    idx,
  output logic                   update_settings_out
);

  mod_pkg::timer_state_t                  state;
  logic [mod_pkg::settle_cnt_width-1:0]   cnt;
  logic [mod_pkg::dividend_width-1:0]     time_q;
  logic                                   load_accept;

  assign load_accept = (state == mod_pkg::st_idle) && update_settings_in;

  always_ff @(posedge CLK) begin
    time_q <= sys_time[mod_pkg::time_shift +: mod_pkg::dividend_width];
  end

  ////////////////////
  // index chains
  ////////////////////

  for (genvar i = 0; i < mod_pkg::num_segment; i++) begin : gen_segment
    logic [mod_pkg::divisor_width-1:0]  freq_div_q;
    logic [mod_pkg::divisor_width-1:0]  cycle_q;      // holds cycle+1
    logic [mod_pkg::dividend_width-1:0] period_cnt;
    logic [mod_pkg::dividend_width-1:0] period_cnt_q;
    logic [mod_pkg::divisor_width-1:0]  rem;
    logic [mod_pkg::idx_width-1:0]      idx_q;

    always_ff @(posedge CLK) begin
      if (!rst_n) begin
        freq_div_q <= 16'd1;
        cycle_q    <= 16'd1;
      end else if (load_accept) begin
        freq_div_q <= settings.freq_div[i];
        cycle_q    <= 16'(settings.cycle[i]) + 16'd1;
      end
    end

    always_ff @(posedge CLK) begin
      period_cnt_q <= period_cnt;                  // buffer between dividers
      idx_q        <= rem[mod_pkg::idx_width-1:0];
    end

    pipe_divider u_div_cnt (
      .CLK       (CLK),
      .dividend  (time_q),
      .divisor   (freq_div_q),
      .quotient  (period_cnt),
      .remainder ()
    );

    pipe_divider u_div_idx (
      .CLK       (CLK),
      .dividend  (period_cnt_q),
      .divisor   (cycle_q),
      .quotient  (),
      .remainder (rem)
    );

    assign idx[i] = idx_q;
  end

  ////////////////////
  // settings load
  ////////////////////

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      state               <= mod_pkg::st_idle;
      cnt                 <= '0;
      update_settings_out <= 1'b0;
    end else begin
      update_settings_out <= 1'b0;
      case (state)
        mod_pkg::st_idle: begin
          cnt <= '0;
          if (update_settings_in) state <= mod_pkg::st_load;
        end
        mod_pkg::st_load: begin
          cnt <= cnt + 1'b1;  // wait for both dividers to drain
          if (cnt == mod_pkg::settle_last) begin
            update_settings_out <= 1'b1;
            state               <= mod_pkg::st_idle;
          end
        end
        default: state <= mod_pkg::st_idle;
      endcase
    end
  end

endmodule

/* verilog/pipe_divider.sv */
module pipe_divider (
  input  logic                               CLK,
  input  logic [mod_pkg::dividend_width-1:0] dividend,
  input  logic [mod_pkg::divisor_width-1:0]  divisor,
  output logic [mod_pkg::dividend_width-1:0] quotient,
  output logic [mod_pkg::divisor_width-1:0]  remainder
);

  // stage 0 is the input register and stages 1..48 resolve one bit each
  logic [mod_pkg::divisor_width-1:0]  rem_q [1:mod_pkg::div_latency-1];
  logic [mod_pkg::dividend_width-1:0] dq_q  [mod_pkg::div_latency];  // dividend out as quotient in
  logic [mod_pkg::divisor_width-1:0]  div_q [mod_pkg::div_latency];

  ////////////////////
  // input register
  ////////////////////

  always_ff @(posedge CLK) begin
    dq_q[0]  <= dividend;
    div_q[0] <= divisor;
  end

  ////////////////////
  // bit stages
  ////////////////////

  for (genvar s = 1; s < mod_pkg::div_latency; s++) begin : gen_stage
    logic [mod_pkg::divisor_width:0] trial;  // partial remainder with next bit
    logic                            fits;

    if (s == 1) begin : gen_first
      assign trial = {{mod_pkg::divisor_width{1'b0}}, dq_q[0][mod_pkg::dividend_width-1]};
    end else begin : gen_next
      assign trial = {rem_q[s-1], dq_q[s-1][mod_pkg::dividend_width-1]};
    end

    assign fits = trial >= {1'b0, div_q[s-1]};

    always_ff @(posedge CLK) begin
      if (fits) begin
        rem_q[s] <= mod_pkg::divisor_width'(trial - {1'b0, div_q[s-1]});
      end else begin
        rem_q[s] <= trial[mod_pkg::divisor_width-1:0];
      end
      dq_q[s]  <= {dq_q[s-1][mod_pkg::dividend_width-2:0], fits};  // shift in quotient bit
      div_q[s] <= div_q[s-1];  // divisor travels with its data
    end
  end

  assign quotient  = dq_q[mod_pkg::div_latency-1];
  assign remainder = rem_q[mod_pkg::div_latency-1];

endmodule

/* verilog/mod_pkg.sv */
package mod_pkg;

  ////////////////////
  // sizes
  ////////////////////

  localparam int num_segment  = 2;
  localparam int idx_width    = 15;
  localparam int sample_width = 8;
  localparam int mem_depth    = 2 ** idx_width;

  localparam int time_shift     = 8;   // low time bits dropped
  localparam int dividend_width = 48;
  localparam int divisor_width  = 16;

  // input register plus one stage per dividend bit
  localparam int div_latency   = dividend_width + 1;
  localparam int settle_cycles = 2 * div_latency + 3;

  localparam int settle_cnt_width = $clog2(settle_cycles);
  localparam logic [settle_cnt_width-1:0] settle_last = settle_cnt_width'(settle_cycles - 1);

  ////////////////////
  // types
  ////////////////////

  typedef enum logic {
    st_idle,
    st_load
  } timer_state_t;

  typedef struct packed {
    logic [num_segment-1:0][idx_width-1:0]     cycle;     // last index of each segment
    logic [num_segment-1:0][divisor_width-1:0] freq_div;  // time units per sample
  } mod_settings_t;

  typedef logic [num_segment-1:0][idx_width-1:0] idx_array_t;

  typedef struct packed {
    logic                    en;
    logic [0:0]              segment;
    logic [idx_width-1:0]    addr;
    logic [sample_width-1:0] data;
  } mod_write_t;

endpackage
